// ==== logic/neuron_defines.svh ====
// NEURON_LANES must be a power of two, and NEURON_LANES/2 lanes of DATA_WIDTH must fill ACC_WIDTH
`ifndef NEURON_DEFINES_SVH
`define NEURON_DEFINES_SVH

// activations per input vector
`define NEURON_LANES 8

// signed activation and weight width
`define DATA_WIDTH 8

// accumulator and bias width
`define ACC_WIDTH 32

// clamped output width
`define OUT_WIDTH 16

// host write addresses
`define ADDR_WEIGHTS_LO 2'd0
`define ADDR_WEIGHTS_HI 2'd1
`define ADDR_BIAS 2'd2

`endif

// ==== logic/neuronPkg.sv ====
// types are sized from neuron_defines.svh; the host word assumes half the lanes fill one bias word
`include "neuron_defines.svh"

package neuronPkg;

    typedef logic signed [`DATA_WIDTH-1:0] dataWord_t;
    typedef logic signed [2*`DATA_WIDTH-1:0] product_t;

    // lane 0 sits in the low bits
    typedef struct packed {
        dataWord_t [`NEURON_LANES-1:0] lane;
    } actVector_t;

    typedef struct packed {
        product_t [`NEURON_LANES-1:0] lane;
    } productVector_t;

    // one host word, read as half a weight bank or as the bias
    typedef union packed {
        dataWord_t [`NEURON_LANES/2-1:0] weightLanes;
        logic signed [`ACC_WIDTH-1:0] bias;
    } hostWord_u;

    typedef struct packed {
        logic [1:0] addr;
        hostWord_u word;
    } hostWrite_t;

    typedef struct packed {
        logic productValid;
        logic clearAcc;
        logic accumEn;
        logic finalize;
    } stageCtrl_t;

endpackage

// ==== logic/neuronControl.sv ====
// no back-pressure; host writes are simply dropped while busy, a group ends on the inLast vector
`timescale 1ns/100ps
`include "neuron_defines.svh"

module neuronControl import neuronPkg::*; (
    input logic clk,
    input logic rstN,
    input logic wrEn,
    input logic inValid,
    input logic inLast,
    output logic wrGranted,
    output stageCtrl_t stage,
    output logic busy
);

    // high between the first and the last vector of a group
    logic groupOpen;
    // valid per stage: products, accumulate/finalize, output
    logic [2:0] validPipe;
    logic firstStage;
    logic lastStage;
    // a non-last vector of the current group has been accumulated
    logic accumSeen;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            groupOpen <= 1'b0;
            validPipe <= '0;
            firstStage <= 1'b0;
            lastStage <= 1'b0;
            accumSeen <= 1'b0;
        end else begin
            validPipe <= {validPipe[1:0], inValid};
            firstStage <= inValid & ~groupOpen;
            lastStage <= inValid & inLast;
            if (inValid) begin
                groupOpen <= ~inLast;
            end
            if (stage.accumEn) begin
                accumSeen <= ~stage.finalize;
            end
        end
    end

    // strobes line up with the registered products
    always_comb begin
        stage.productValid = validPipe[0];
        stage.clearAcc = firstStage;
        stage.accumEn = validPipe[0];
        stage.finalize = lastStage;
    end

    // stays up through the outValid cycle
    assign busy = inValid | groupOpen | (|validPipe);
    assign wrGranted = wrEn & ~busy;

    finalizeAfterAccum: assert property (@(posedge clk) disable iff (!rstN)
        stage.finalize |-> stage.accumEn && (stage.clearAcc || accumSeen))
        else $error("finalize without accumulation in the same group");

endmodule

// ==== logic/weightBank.sv ====
// weights and bias reset to zero; writes to unmapped addresses leave the bank unchanged
`timescale 1ns/100ps
`include "neuron_defines.svh"

module weightBank import neuronPkg::*; (
    input logic clk,
    input logic rstN,
    input logic wrGranted,
    input hostWrite_t wrCmd,
    output actVector_t weights,
    output logic signed [`ACC_WIDTH-1:0] bias
);

    localparam int halfLanes = `NEURON_LANES / 2;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            weights <= '0;
            bias <= '0;
        end else if (wrGranted) begin
            case (wrCmd.addr)
                `ADDR_WEIGHTS_LO: begin
                    for (int i = 0; i < halfLanes; i++) begin
                        weights.lane[i] <= wrCmd.word.weightLanes[i];
                    end
                end
                `ADDR_WEIGHTS_HI: begin
                    // upper half of the bank
                    for (int i = 0; i < halfLanes; i++) begin
                        weights.lane[i + halfLanes] <= wrCmd.word.weightLanes[i];
                    end
                end
                `ADDR_BIAS: begin
                    bias <= wrCmd.word.bias;
                end
                default: begin
                end
            endcase
        end
    end

    mappedWrite: assert property (@(posedge clk) disable iff (!rstN)
        wrGranted |-> wrCmd.addr inside {`ADDR_WEIGHTS_LO, `ADDR_WEIGHTS_HI, `ADDR_BIAS})
        else $error("granted write to unmapped address %0d", wrCmd.addr);

endmodule

// ==== logic/productArray.sv ====
// products are held between valid vectors and have no reset
`timescale 1ns/100ps
`include "neuron_defines.svh"

module productArray import neuronPkg::*; (
    input logic clk,
    input logic inValid,
    input actVector_t inVector,
    input actVector_t weights,
    output productVector_t products
);

    productVector_t laneProducts;

    // full 16 bit signed products, no rounding
    always_comb begin
        for (int i = 0; i < `NEURON_LANES; i++) begin
            laneProducts.lane[i] = $signed(inVector.lane[i]) * $signed(weights.lane[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            products <= laneProducts;
        end
    end

endmodule

// ==== logic/binaryTreeAdder.sv ====
// INPUTS_AMOUNT must be a power of two matching the product lanes; the tree has no pipeline registers
`timescale 1ns/100ps
`include "neuron_defines.svh"

module binaryTreeAdder import neuronPkg::*; #(
    parameter int INPUTS_AMOUNT = `NEURON_LANES,
    parameter int P = 2 * `DATA_WIDTH
) (
    input productVector_t products,
    output logic signed [`ACC_WIDTH-1:0] sum
);

    localparam int layerAmount = $clog2(INPUTS_AMOUNT);
    localparam int sumWidth = P + layerAmount;

    if (INPUTS_AMOUNT < 2 || (INPUTS_AMOUNT & (INPUTS_AMOUNT - 1)) != 0) begin : genSizeCheck
        $fatal(1, "binaryTreeAdder: INPUTS_AMOUNT %0d is not a power of two", INPUTS_AMOUNT);
    end
    if ($bits(productVector_t) != INPUTS_AMOUNT * P || sumWidth > `ACC_WIDTH) begin : genWidthCheck
        $fatal(1, "binaryTreeAdder: lane count or width does not fit the product vector");
    end

    logic signed [P-1:0] leaves [INPUTS_AMOUNT];
    logic signed [sumWidth-1:0] treeRoot;

    for (genvar i = 0; i < INPUTS_AMOUNT; i++) begin : genLeaf
        assign leaves[i] = products.lane[i];
    end

    // each layer halves the node count and grows one bit
    for (genvar layer = 0; layer < layerAmount; layer++) begin : genLayer
        localparam int nodeCount = INPUTS_AMOUNT >> (layer + 1);
        logic signed [P+layer:0] node [nodeCount];

        for (genvar k = 0; k < nodeCount; k++) begin : genAdder
            if (layer == 0) begin : genFirst
                assign node[k] = leaves[2*k] + leaves[2*k+1];
            end else begin : genInner
                assign node[k] = genLayer[layer-1].node[2*k] + genLayer[layer-1].node[2*k+1];
            end
        end
    end

    assign treeRoot = genLayer[layerAmount-1].node[0];

    // sign extend to the accumulator
    assign sum = {{(`ACC_WIDTH - sumWidth){treeRoot[sumWidth-1]}}, treeRoot};

endmodule

// ==== logic/accumulateActivate.sv ====
// accumulation wraps at ACC_WIDTH; the bias add is one bit wider, then ReLU and a clamp to OUT_WIDTH
`timescale 1ns/100ps
`include "neuron_defines.svh"

module accumulateActivate import neuronPkg::*; (
    input logic clk,
    input logic rstN,
    input stageCtrl_t stage,
    input logic signed [`ACC_WIDTH-1:0] sum,
    input logic signed [`ACC_WIDTH-1:0] bias,
    output logic outValid,
    output logic signed [`OUT_WIDTH-1:0] outValue
);

    localparam logic signed [`ACC_WIDTH:0] outMax = (1 <<< (`OUT_WIDTH - 1)) - 1;

    logic signed [`ACC_WIDTH-1:0] accReg;
    logic signed [`ACC_WIDTH-1:0] accNow;
    logic signed [`ACC_WIDTH-1:0] addend;
    logic signed [`ACC_WIDTH:0] biased;
    logic signed [`OUT_WIDTH-1:0] activated;
    logic finalPending;

    // first vector of a group starts from zero
    always_comb begin
        addend = stage.productValid ? sum : '0;
        accNow = (stage.clearAcc ? '0 : accReg) + addend;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            accReg <= '0;
            finalPending <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (stage.accumEn) begin
                accReg <= accNow;
            end
            finalPending <= stage.finalize;
            outValid <= finalPending;
        end
    end

    // captured before a following group can clear the accumulator
    always_ff @(posedge clk) begin
        if (stage.finalize) begin
            biased <= accNow + bias;
        end
        if (finalPending) begin
            outValue <= activated;
        end
    end

    // relu, then saturate
    always_comb begin
        if (biased < 0) begin
            activated = '0;
        end else if (biased > outMax) begin
            activated = outMax[`OUT_WIDTH-1:0];
        end else begin
            activated = biased[`OUT_WIDTH-1:0];
        end
    end

    nonNegativeOut: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !outValue[`OUT_WIDTH-1])
        else $error("negative output 0x%h after activation", outValue);

endmodule

// ==== logic/neuronCore.sv ====
// single neuron; result appears three cycles after the inLast vector is sampled, pulses are not held
`timescale 1ns/100ps
`include "neuron_defines.svh"

module neuronCore import neuronPkg::*; (
    input logic clk,
    input logic rstN,
    input logic wrEn,
    input hostWrite_t wrCmd,
    input logic inValid,
    input logic inLast,
    input actVector_t inVector,
    output logic outValid,
    output logic signed [`OUT_WIDTH-1:0] outValue,
    output logic busy
);

    logic wrGranted;
    stageCtrl_t stage;
    actVector_t weights;
    logic signed [`ACC_WIDTH-1:0] bias;
    productVector_t products;
    logic signed [`ACC_WIDTH-1:0] treeSum;

    neuronControl control (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .inValid(inValid),
        .inLast(inLast),
        .wrGranted(wrGranted),
        .stage(stage),
        .busy(busy)
    );

    weightBank bank (
        .clk(clk),
        .rstN(rstN),
        .wrGranted(wrGranted),
        .wrCmd(wrCmd),
        .weights(weights),
        .bias(bias)
    );

    productArray multiply (
        .clk(clk),
        .inValid(inValid),
        .inVector(inVector),
        .weights(weights),
        .products(products)
    );

    binaryTreeAdder #(
        .INPUTS_AMOUNT(`NEURON_LANES),
        .P(2 * `DATA_WIDTH)
    ) tree (
        .products(products),
        .sum(treeSum)
    );

    accumulateActivate activate (
        .clk(clk),
        .rstN(rstN),
        .stage(stage),
        .sum(treeSum),
        .bias(bias),
        .outValid(outValid),
        .outValue(outValue)
    );

endmodule

// ==== tests/tbNeuronCore.sv ====
// results are expected three cycles after the last vector is driven; model sums do not wrap
`timescale 1ns/100ps
`include "neuron_defines.svh"

module tbNeuronCore import neuronPkg::*; ();

    localparam int testCount = 5;
    localparam int cyclesPerTest = 40;
    localparam int timeoutCycles = testCount * cyclesPerTest + 100;
    localparam int driveDelay = 2;

    logic clk;
    logic rstN;
    logic wrEn;
    hostWrite_t wrCmd;
    logic inValid;
    logic inLast;
    actVector_t inVector;
    logic outValid;
    logic signed [`OUT_WIDTH-1:0] outValue;
    logic busy;

    integer seed;
    int cycleCount;
    int errorCount;
    int testsPassed;
    int testsFailed;
    // reference model state
    int modelWeight [`NEURON_LANES];
    longint modelBias;
    longint groupTotal;
    int expCycleQ [$];
    logic [`OUT_WIDTH-1:0] expValueQ [$];

    neuronCore uut (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .wrCmd(wrCmd),
        .inValid(inValid),
        .inLast(inLast),
        .inVector(inVector),
        .outValid(outValid),
        .outValue(outValue),
        .busy(busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("run stopped after %0d cycles without finishing", cycleCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // every output cycle is compared with the queued expectations
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            if (expCycleQ.size() > 0 && expCycleQ[0] == cycleCount) begin
                if (outValid !== 1'b1) begin
                    $display("FAILED outValid expected 1 got %h", outValid);
                    errorCount++;
                end else if (outValue !== expValueQ[0]) begin
                    $display("FAILED outValue expected %h got %h", expValueQ[0], outValue);
                    errorCount++;
                end
                void'(expCycleQ.pop_front());
                void'(expValueQ.pop_front());
            end else if (outValid !== 1'b0) begin
                $display("output pulse at cycle %0d where none was expected", cycleCount);
                errorCount++;
            end
        end
    end

    function automatic longint reluClamp(input longint total);
        if (total < 0) begin
            return 0;
        end
        return (total > 32767) ? 32767 : total;
    endfunction

    function automatic logic [31:0] packLanes(input int b0, input int b1,
                                              input int b2, input int b3);
        return {b3[7:0], b2[7:0], b1[7:0], b0[7:0]};
    endfunction

    function automatic actVector_t randomVector(input logic [7:0] mask);
        actVector_t vec;
        logic [31:0] r;
        for (int i = 0; i < `NEURON_LANES; i++) begin
            r = $random(seed);
            vec.lane[i] = r[7:0] & mask;
        end
        return vec;
    endfunction

    task automatic checkBusy(input logic expected);
        if (busy !== expected) begin
            $display("FAILED busy expected %h got %h", expected, busy);
            errorCount++;
        end
    endtask

    // host write that the model takes as accepted
    task automatic loadWord(input logic [1:0] addr, input logic [31:0] data);
        int base;
        base = (addr == `ADDR_WEIGHTS_HI) ? `NEURON_LANES / 2 : 0;
        if (addr == `ADDR_BIAS) begin
            modelBias = longint'($signed(data));
        end else begin
            for (int i = 0; i < `NEURON_LANES / 2; i++) begin
                modelWeight[base + i] = int'($signed(data[8*i +: 8]));
            end
        end
        wrEn = 1'b1;
        wrCmd.addr = addr;
        wrCmd.word = data;
        @(posedge clk);
        #driveDelay;
        wrEn = 1'b0;
    endtask

    task automatic sendVector(input actVector_t vec, input logic last);
        logic [`OUT_WIDTH-1:0] expected;
        for (int i = 0; i < `NEURON_LANES; i++) begin
            groupTotal += longint'($signed(vec.lane[i])) * modelWeight[i];
        end
        inValid = 1'b1;
        inLast = last;
        inVector = vec;
        if (last) begin
            expected = reluClamp(groupTotal + modelBias);
            expCycleQ.push_back(cycleCount + 3);
            expValueQ.push_back(expected);
            groupTotal = 0;
        end
        @(posedge clk);
        #driveDelay;
        inValid = 1'b0;
        inLast = 1'b0;
    endtask

    task automatic waitResults();
        while (expCycleQ.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        #driveDelay;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("test %s passed", name);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic testResetDefaults();
        int errorsBefore;
        errorsBefore = errorCount;
        checkBusy(1'b0);
        sendVector(randomVector(8'hff), 1'b1);
        waitResults();
        // idle again once the result has gone out
        checkBusy(1'b0);
        finishTest("reset defaults", errorsBefore);
    endtask

    task automatic testWeightLoad();
        int errorsBefore;
        actVector_t vec;
        errorsBefore = errorCount;
        loadWord(`ADDR_WEIGHTS_LO, packLanes(-3, 7, -128, 127));
        loadWord(`ADDR_WEIGHTS_HI, packLanes(5, -1, 100, -50));
        loadWord(`ADDR_BIAS, 32'd1234);
        // distinct lane values expose any lane swap
        for (int i = 0; i < `NEURON_LANES; i++) begin
            vec.lane[i] = 8'(i + 1);
        end
        sendVector(vec, 1'b1);
        waitResults();
        finishTest("weight load", errorsBefore);
    endtask

    task automatic testBackToBack();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < 5; i++) begin
            sendVector(randomVector(8'hff), i == 4);
        end
        // second group starts right after inLast
        for (int i = 0; i < 3; i++) begin
            sendVector(randomVector(8'h3f), i == 2);
        end
        waitResults();
        finishTest("back to back groups", errorsBefore);
    endtask

    task automatic testActivation();
        int errorsBefore;
        actVector_t vec;
        errorsBefore = errorCount;
        loadWord(`ADDR_BIAS, -32'sd1000000);
        sendVector(randomVector(8'hff), 1'b1);
        waitResults();
        loadWord(`ADDR_WEIGHTS_LO, packLanes(127, 127, 127, 127));
        loadWord(`ADDR_WEIGHTS_HI, packLanes(127, 127, 127, 127));
        loadWord(`ADDR_BIAS, 32'd0);
        for (int i = 0; i < `NEURON_LANES; i++) begin
            vec.lane[i] = 8'sd127;
        end
        sendVector(vec, 1'b1);
        waitResults();
        finishTest("relu and clamp", errorsBefore);
    endtask

    task automatic testDroppedWrite();
        int errorsBefore;
        errorsBefore = errorCount;
        loadWord(`ADDR_WEIGHTS_LO, packLanes(2, 3, 4, 5));
        loadWord(`ADDR_WEIGHTS_HI, packLanes(6, 7, 8, 9));
        loadWord(`ADDR_BIAS, 32'd100);
        sendVector(randomVector(8'h0f), 1'b0);
        // group is open, so the write below must be refused
        checkBusy(1'b1);
        // model keeps the old weights
        wrEn = 1'b1;
        wrCmd.addr = `ADDR_WEIGHTS_LO;
        wrCmd.word = packLanes(-20, -20, -20, -20);
        sendVector(randomVector(8'h0f), 1'b0);
        wrEn = 1'b0;
        sendVector(randomVector(8'h0f), 1'b1);
        waitResults();
        sendVector(randomVector(8'h0f), 1'b1);
        waitResults();
        finishTest("write while busy", errorsBefore);
    endtask

    initial begin
        seed = 32'he95bd456;
        clk = 1'b0;
        rstN = 1'b0;
        wrEn = 1'b0;
        wrCmd = '0;
        inValid = 1'b0;
        inLast = 1'b0;
        inVector = '0;
        groupTotal = 0;
        modelBias = 0;
        for (int i = 0; i < `NEURON_LANES; i++) begin
            modelWeight[i] = 0;
        end
        repeat (3) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        testResetDefaults();
        testWeightLoad();
        testBackToBack();
        testActivation();
        testDroppedWrite();
        $display("tests passed %0d failed %0d, check errors %0d",
            testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== neuronCore.f ====
+incdir+logic
logic/neuronPkg.sv
logic/neuronControl.sv
logic/weightBank.sv
logic/productArray.sv
logic/binaryTreeAdder.sv
logic/accumulateActivate.sv
logic/neuronCore.sv
tests/tbNeuronCore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f neuronCore.f \
    --top-module tbNeuronCore -o simNeuronCore
output=$(./obj_dir/simNeuronCore)
echo "$output"
echo "$output" | grep -q "STATUS: PASS"
